//--- include/riscv_macros.svh
`ifndef RISCV_MACROS_SVH
`define RISCV_MACROS_SVH

// Data and address width
`define XLEN 32

// First fetch address
`define RESET_PC 32'h0000_0000

// ADDI x0, x0, 0
`define INST_NOP 32'h0000_0013

// Architectural integer registers
`define REG_COUNT 32

`endif

//--- verilog/riscv_pkg.sv
`default_nettype none

`include "riscv_macros.svh"

package riscv_pkg;

    // Major opcodes of the supported RV32I subset
    typedef enum logic [6:0] {
        OP_REG    = 7'b0110011,
        OP_IMM    = 7'b0010011,
        OP_LUI    = 7'b0110111,
        OP_LOAD   = 7'b0000011,
        OP_STORE  = 7'b0100011,
        OP_BRANCH = 7'b1100011,
        OP_JAL    = 7'b1101111
    } opcode_e;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_PASS_B
    } alu_op_e;

    // Writeback source
    typedef enum logic [1:0] {
        SRC_ALU,
        SRC_MEM,
        SRC_PC_PLUS4
    } reg_src_e;

    // Operand source seen by the execute stage
    typedef enum logic [1:0] {
        FWD_REG,
        FWD_FROM_MEM,
        FWD_FROM_WB
    } fwd_sel_e;

    typedef struct packed {
        logic              reg_write;
        logic              mem_read;
        logic              mem_write;
        logic              branch;
        logic              jal;
        logic              alu_src_imm;
        alu_op_e           alu_op;
        reg_src_e          reg_src;
        logic [4:0]        rs1;
        logic [4:0]        rs2;
        logic [4:0]        rd;
        logic [`XLEN-1:0]  pc;
        logic [`XLEN-1:0]  pc_plus4;
        logic [`XLEN-1:0]  rs1_data;
        logic [`XLEN-1:0]  rs2_data;
        logic [`XLEN-1:0]  imm;
    } id_ex_t;

    typedef struct packed {
        logic              reg_write;
        logic              mem_read;
        logic              mem_write;
        reg_src_e          reg_src;
        logic [4:0]        rd;
        logic [`XLEN-1:0]  alu_result;
        logic [`XLEN-1:0]  store_data;
        logic [`XLEN-1:0]  pc_plus4;
    } ex_mem_t;

    typedef struct packed {
        logic              reg_write;
        logic [4:0]        rd;
        logic [`XLEN-1:0]  wb_data;
    } mem_wb_t;

endpackage

`default_nettype wire

//--- verilog/riscv_regfile.sv
`timescale 1ns/10ps
`default_nettype none

`include "riscv_macros.svh"

module riscv_regfile (
    input  logic               clk,
    input  logic               rst,
    input  logic [4:0]         rs1_addr,
    input  logic [4:0]         rs2_addr,
    input  logic               we,
    input  logic [4:0]         waddr,
    input  logic [`XLEN-1:0]   wdata,
    output logic [`XLEN-1:0]   rs1_data,
    output logic [`XLEN-1:0]   rs2_data
);

    logic [`XLEN-1:0] regs [`REG_COUNT];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (we && waddr != 5'd0) begin
            regs[waddr] <= wdata;
        end
    end

    // x0 reads zero; a same-cycle write is visible to ID
    assign rs1_data = (rs1_addr == 5'd0)                ? '0    :
                      (we && waddr == rs1_addr)         ? wdata :
                                                          regs[rs1_addr];
    assign rs2_data = (rs2_addr == 5'd0)                ? '0    :
                      (we && waddr == rs2_addr)         ? wdata :
                                                          regs[rs2_addr];

endmodule

`default_nettype wire

//--- verilog/riscv_hazard_unit.sv
`timescale 1ns/10ps
`default_nettype none

module riscv_hazard_unit (
    input  riscv_pkg::id_ex_t   id_ex,
    input  riscv_pkg::ex_mem_t  ex_mem,
    input  riscv_pkg::mem_wb_t  mem_wb,
    input  logic [4:0]          if_id_rs1,
    input  logic [4:0]          if_id_rs2,
    input  logic                redirect,
    output riscv_pkg::fwd_sel_e rs1_fwd,
    output riscv_pkg::fwd_sel_e rs2_fwd,
    output logic                stall,
    output logic                flush
);
    import riscv_pkg::*;

    logic load_use;

    // MEM result is younger than WB, so it takes priority
    function automatic fwd_sel_e pick_src(input logic [4:0] rs, input ex_mem_t em,
                                          input mem_wb_t mw);
        fwd_sel_e sel;
        sel = FWD_REG;
        if (em.reg_write && em.rd != 5'd0 && em.rd == rs) begin
            sel = FWD_FROM_MEM;
        end else if (mw.reg_write && mw.rd != 5'd0 && mw.rd == rs) begin
            sel = FWD_FROM_WB;
        end
        return sel;
    endfunction

    assign rs1_fwd = pick_src(id_ex.rs1, ex_mem, mem_wb);
    assign rs2_fwd = pick_src(id_ex.rs2, ex_mem, mem_wb);

    assign load_use = id_ex.mem_read && id_ex.rd != 5'd0 &&
                      (id_ex.rd == if_id_rs1 || id_ex.rd == if_id_rs2);

    // A redirect discards the dependent instruction anyway
    assign stall = load_use && !redirect;
    assign flush = redirect;

endmodule

`default_nettype wire

//--- verilog/riscv_front_end.sv
`timescale 1ns/10ps
`default_nettype none

`include "riscv_macros.svh"

module riscv_front_end (
    input  logic               clk,
    input  logic               rst,
    input  logic [`XLEN-1:0]   instr,
    input  logic               stall,
    input  logic               flush,
    input  logic               redirect,
    input  logic [`XLEN-1:0]   redirect_pc,
    input  logic [`XLEN-1:0]   rs1_data,
    input  logic [`XLEN-1:0]   rs2_data,
    output logic [`XLEN-1:0]   pc,
    output logic [4:0]         rs1_addr,
    output logic [4:0]         rs2_addr,
    output riscv_pkg::id_ex_t  id_ex,
    output logic [4:0]         if_id_rs1,
    output logic [4:0]         if_id_rs2
);
    import riscv_pkg::*;

    logic [`XLEN-1:0] if_id_instr;
    logic [`XLEN-1:0] if_id_pc;
    opcode_e          opcode;
    logic             use_rs1;
    logic             use_rs2;
    id_ex_t           id_next;

    // Redirect wins over the load-use hold
    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= `RESET_PC;
        end else if (redirect) begin
            pc <= redirect_pc;
        end else if (!stall) begin
            pc <= pc + `XLEN'd4;
        end
    end

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            if_id_instr <= `INST_NOP;
        end else if (!stall) begin
            if_id_instr <= instr;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            if_id_pc <= pc;
        end
    end

    assign opcode   = opcode_e'(if_id_instr[6:0]);
    assign rs1_addr = if_id_instr[19:15];
    assign rs2_addr = if_id_instr[24:20];

    // Only real source operands take part in hazard checks
    always_comb begin
        use_rs1 = 1'b0;
        use_rs2 = 1'b0;
        case (opcode)
            OP_REG, OP_STORE, OP_BRANCH: begin
                use_rs1 = 1'b1;
                use_rs2 = 1'b1;
            end
            OP_IMM, OP_LOAD: use_rs1 = 1'b1;
            default: ;
        endcase
    end

    assign if_id_rs1 = use_rs1 ? rs1_addr : 5'd0;
    assign if_id_rs2 = use_rs2 ? rs2_addr : 5'd0;

    always_comb begin
        id_next          = '0;
        id_next.alu_op   = ALU_ADD;
        id_next.reg_src  = SRC_ALU;
        id_next.rs1      = if_id_rs1;
        id_next.rs2      = if_id_rs2;
        id_next.rd       = if_id_instr[11:7];
        id_next.pc       = if_id_pc;
        id_next.pc_plus4 = if_id_pc + `XLEN'd4;
        id_next.rs1_data = rs1_data;
        id_next.rs2_data = rs2_data;
        case (opcode)
            OP_REG: begin
                id_next.reg_write = 1'b1;
                case (if_id_instr[14:12])
                    3'b000:  id_next.alu_op = if_id_instr[30] ? ALU_SUB : ALU_ADD;
                    3'b010:  id_next.alu_op = ALU_SLT;
                    3'b100:  id_next.alu_op = ALU_XOR;
                    3'b110:  id_next.alu_op = ALU_OR;
                    3'b111:  id_next.alu_op = ALU_AND;
                    default: id_next.alu_op = ALU_ADD;
                endcase
            end
            OP_IMM: begin
                id_next.reg_write   = 1'b1;
                id_next.alu_src_imm = 1'b1;
                id_next.imm         = {{20{if_id_instr[31]}}, if_id_instr[31:20]};
            end
            OP_LUI: begin
                id_next.reg_write   = 1'b1;
                id_next.alu_src_imm = 1'b1;
                id_next.alu_op      = ALU_PASS_B;
                id_next.imm         = {if_id_instr[31:12], 12'd0};
            end
            OP_LOAD: begin
                id_next.reg_write   = 1'b1;
                id_next.mem_read    = 1'b1;
                id_next.alu_src_imm = 1'b1;
                id_next.reg_src     = SRC_MEM;
                id_next.imm         = {{20{if_id_instr[31]}}, if_id_instr[31:20]};
            end
            OP_STORE: begin
                id_next.mem_write   = 1'b1;
                id_next.alu_src_imm = 1'b1;
                id_next.imm         = {{20{if_id_instr[31]}}, if_id_instr[31:25],
                                       if_id_instr[11:7]};
            end
            OP_BRANCH: begin
                id_next.branch = 1'b1;
                id_next.imm    = {{19{if_id_instr[31]}}, if_id_instr[31], if_id_instr[7],
                                  if_id_instr[30:25], if_id_instr[11:8], 1'b0};
            end
            OP_JAL: begin
                id_next.reg_write = 1'b1;
                id_next.jal       = 1'b1;
                id_next.reg_src   = SRC_PC_PLUS4;
                id_next.imm       = {{11{if_id_instr[31]}}, if_id_instr[31],
                                     if_id_instr[19:12], if_id_instr[20],
                                     if_id_instr[30:21], 1'b0};
            end
            default: ;
        endcase
        // Bubble into EX
        if (stall || flush) begin
            id_next.reg_write   = 1'b0;
            id_next.mem_read    = 1'b0;
            id_next.mem_write   = 1'b0;
            id_next.branch      = 1'b0;
            id_next.jal         = 1'b0;
            id_next.alu_src_imm = 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            id_ex.reg_write   <= 1'b0;
            id_ex.mem_read    <= 1'b0;
            id_ex.mem_write   <= 1'b0;
            id_ex.branch      <= 1'b0;
            id_ex.jal         <= 1'b0;
            id_ex.alu_src_imm <= 1'b0;
        end else begin
            id_ex <= id_next;
        end
    end

endmodule

`default_nettype wire

//--- verilog/riscv_execute.sv
`timescale 1ns/10ps
`default_nettype none

`include "riscv_macros.svh"

module riscv_execute (
    input  logic                clk,
    input  logic                rst,
    input  riscv_pkg::id_ex_t   id_ex,
    input  riscv_pkg::fwd_sel_e rs1_fwd,
    input  riscv_pkg::fwd_sel_e rs2_fwd,
    input  logic [`XLEN-1:0]    wb_data,
    output riscv_pkg::ex_mem_t  ex_mem,
    output logic                redirect,
    output logic [`XLEN-1:0]    redirect_pc
);
    import riscv_pkg::*;

    logic [`XLEN-1:0] wb_stage_data;
    logic [`XLEN-1:0] op_a;
    logic [`XLEN-1:0] op_b_reg;
    logic [`XLEN-1:0] op_b;
    logic [`XLEN-1:0] alu_result;
    ex_mem_t          ex_next;

    function automatic logic [`XLEN-1:0] fwd_mux(input fwd_sel_e sel,
                                                 input logic [`XLEN-1:0] reg_val,
                                                 input logic [`XLEN-1:0] mem_val,
                                                 input logic [`XLEN-1:0] wb_val);
        case (sel)
            FWD_FROM_MEM: return mem_val;
            FWD_FROM_WB:  return wb_val;
            default:      return reg_val;
        endcase
    endfunction

    // wb_data is the MEM-stage result; one cycle later it is the WB value
    always_ff @(posedge clk) begin
        wb_stage_data <= wb_data;
    end

    assign op_a     = fwd_mux(rs1_fwd, id_ex.rs1_data, wb_data, wb_stage_data);
    assign op_b_reg = fwd_mux(rs2_fwd, id_ex.rs2_data, wb_data, wb_stage_data);
    assign op_b     = id_ex.alu_src_imm ? id_ex.imm : op_b_reg;

    always_comb begin
        case (id_ex.alu_op)
            ALU_SUB:    alu_result = op_a - op_b;
            ALU_AND:    alu_result = op_a & op_b;
            ALU_OR:     alu_result = op_a | op_b;
            ALU_XOR:    alu_result = op_a ^ op_b;
            ALU_SLT:    alu_result = {{(`XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            ALU_PASS_B: alu_result = op_b;
            default:    alu_result = op_a + op_b;
        endcase
    end

    // BEQ and JAL share the pc-relative target
    assign redirect    = id_ex.jal || (id_ex.branch && op_a == op_b_reg);
    assign redirect_pc = id_ex.pc + id_ex.imm;

    always_comb begin
        ex_next.reg_write  = id_ex.reg_write;
        ex_next.mem_read   = id_ex.mem_read;
        ex_next.mem_write  = id_ex.mem_write;
        ex_next.reg_src    = id_ex.reg_src;
        ex_next.rd         = id_ex.rd;
        ex_next.alu_result = alu_result;
        ex_next.store_data = op_b_reg;
        ex_next.pc_plus4   = id_ex.pc_plus4;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ex_mem.reg_write <= 1'b0;
            ex_mem.mem_read  <= 1'b0;
            ex_mem.mem_write <= 1'b0;
        end else begin
            ex_mem <= ex_next;
        end
    end

endmodule

`default_nettype wire

//--- verilog/riscv_mem_wb.sv
`timescale 1ns/10ps
`default_nettype none

`include "riscv_macros.svh"

module riscv_mem_wb (
    input  logic               clk,
    input  logic               rst,
    input  riscv_pkg::ex_mem_t ex_mem,
    input  logic [`XLEN-1:0]   mem_read_data,
    output riscv_pkg::mem_wb_t mem_wb,
    output logic [`XLEN-1:0]   wb_data
);
    import riscv_pkg::*;

    logic [`XLEN-1:0] load_data;

    // Data memory answers in the same cycle as mem_addr
    assign load_data = ex_mem.mem_read ? mem_read_data : '0;

    always_comb begin
        case (ex_mem.reg_src)
            SRC_MEM:      wb_data = load_data;
            SRC_PC_PLUS4: wb_data = ex_mem.pc_plus4;
            default:      wb_data = ex_mem.alu_result;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            mem_wb.reg_write <= 1'b0;
        end else begin
            mem_wb.reg_write <= ex_mem.reg_write;
        end
    end

    // Payload of the WB stage
    always_ff @(posedge clk) begin
        mem_wb.rd      <= ex_mem.rd;
        mem_wb.wb_data <= wb_data;
    end

endmodule

`default_nettype wire

//--- verilog/riscv_pipeline.sv
`timescale 1ns/10ps
`default_nettype none

`include "riscv_macros.svh"

module riscv_pipeline (
    input  logic             clk,
    input  logic             rst,
    input  logic [`XLEN-1:0] instr,
    input  logic [`XLEN-1:0] mem_read_data,
    output logic [`XLEN-1:0] instr_addr,
    output logic [`XLEN-1:0] mem_addr,
    output logic [`XLEN-1:0] mem_write_data,
    output logic             ram_write
);
    import riscv_pkg::*;

    logic             stall;
    logic             flush;
    logic             redirect;
    logic [`XLEN-1:0] redirect_pc;
    logic [4:0]       rs1_addr;
    logic [4:0]       rs2_addr;
    logic [4:0]       if_id_rs1;
    logic [4:0]       if_id_rs2;
    logic [`XLEN-1:0] rs1_data;
    logic [`XLEN-1:0] rs2_data;
    logic [`XLEN-1:0] mem_stage_data;
    fwd_sel_e         rs1_fwd;
    fwd_sel_e         rs2_fwd;
    id_ex_t           id_ex;
    ex_mem_t          ex_mem;
    mem_wb_t          mem_wb;

    riscv_front_end front_end_inst (
        .clk(clk), .rst(rst), .instr(instr),
        .stall(stall), .flush(flush),
        .redirect(redirect), .redirect_pc(redirect_pc),
        .rs1_data(rs1_data), .rs2_data(rs2_data),
        .pc(instr_addr), .rs1_addr(rs1_addr), .rs2_addr(rs2_addr),
        .id_ex(id_ex), .if_id_rs1(if_id_rs1), .if_id_rs2(if_id_rs2)
    );

    riscv_regfile regfile_inst (
        .clk(clk), .rst(rst),
        .rs1_addr(rs1_addr), .rs2_addr(rs2_addr),
        .we(mem_wb.reg_write), .waddr(mem_wb.rd), .wdata(mem_wb.wb_data),
        .rs1_data(rs1_data), .rs2_data(rs2_data)
    );

    riscv_hazard_unit hazard_unit_inst (
        .id_ex(id_ex), .ex_mem(ex_mem), .mem_wb(mem_wb),
        .if_id_rs1(if_id_rs1), .if_id_rs2(if_id_rs2), .redirect(redirect),
        .rs1_fwd(rs1_fwd), .rs2_fwd(rs2_fwd), .stall(stall), .flush(flush)
    );

    riscv_execute execute_inst (
        .clk(clk), .rst(rst), .id_ex(id_ex),
        .rs1_fwd(rs1_fwd), .rs2_fwd(rs2_fwd), .wb_data(mem_stage_data),
        .ex_mem(ex_mem), .redirect(redirect), .redirect_pc(redirect_pc)
    );

    riscv_mem_wb mem_wb_inst (
        .clk(clk), .rst(rst), .ex_mem(ex_mem), .mem_read_data(mem_read_data),
        .mem_wb(mem_wb), .wb_data(mem_stage_data)
    );

    // Data memory port
    assign mem_addr       = ex_mem.alu_result;
    assign mem_write_data = ex_mem.store_data;
    assign ram_write      = ex_mem.mem_write;

endmodule

`default_nettype wire

//--- tb/riscv_pipeline_checker.sv
`timescale 1ns/10ps
`default_nettype none

`include "riscv_macros.svh"

module riscv_pipeline_checker (
    input wire logic             clk,
    input wire logic             rst,
    input wire logic [`XLEN-1:0] instr_addr,
    input wire logic [`XLEN-1:0] mem_addr,
    input wire logic [`XLEN-1:0] mem_write_data,
    input wire logic             ram_write
);

    logic [`XLEN-1:0] exp_addr [$];
    logic [`XLEN-1:0] exp_data [$];
    logic [`XLEN-1:0] want_addr;
    logic [`XLEN-1:0] want_data;
    logic             reset_seen = 1'b0;
    logic             first_run = 1'b1;
    int               error_count = 0;
    int               missing_count = 0;

    task automatic expect_store(input logic [`XLEN-1:0] addr, input logic [`XLEN-1:0] data);
        exp_addr.push_back(addr);
        exp_data.push_back(data);
    endtask

    function automatic int pending();
        return exp_addr.size();
    endfunction

    task automatic report_missing();
        if (exp_addr.size() > 0) begin
            missing_count = exp_addr.size();
            $display("%0d expected stores never reached the data memory port", missing_count);
        end
    endtask

    // Sampled on the rising edge while inputs move on the falling edge
    always @(posedge clk) begin
        if (rst) begin
            if (reset_seen && ram_write !== 1'b0) begin
                $display("** Error at %0t: ram_write expected 0 got %b", $time, ram_write);
                error_count++;
            end
            if (reset_seen && instr_addr !== `RESET_PC) begin
                $display("** Error at %0t: instr_addr expected %h got %h",
                         $time, `RESET_PC, instr_addr);
                error_count++;
            end
            reset_seen = 1'b1;
        end else begin
            // Before the first fetch advances
            if (first_run && instr_addr !== `RESET_PC) begin
                $display("** Error at %0t: instr_addr expected %h got %h",
                         $time, `RESET_PC, instr_addr);
                error_count++;
            end
            first_run = 1'b0;
            if (ram_write) begin
                if (exp_addr.size() == 0) begin
                    $display("Unexpected store of %h to %h at %0t",
                             mem_write_data, mem_addr, $time);
                    error_count++;
                end else begin
                    want_addr = exp_addr.pop_front();
                    want_data = exp_data.pop_front();
                    if (mem_addr !== want_addr) begin
                        $display("** Error at %0t: mem_addr expected %h got %h",
                                 $time, want_addr, mem_addr);
                        error_count++;
                    end
                    if (mem_write_data !== want_data) begin
                        $display("** Error at %0t: mem_write_data expected %h got %h",
                                 $time, want_data, mem_write_data);
                        error_count++;
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- tb/riscv_pipeline_assertions.sv
`timescale 1ns/10ps
`default_nettype none

`include "riscv_macros.svh"

module riscv_pipeline_assertions (
    input wire logic                clk,
    input wire logic                rst,
    input wire logic                stall,
    input wire logic                flush,
    input wire logic [`XLEN-1:0]    redirect_pc,
    input wire logic [`XLEN-1:0]    instr_addr,
    input riscv_pkg::id_ex_t        id_ex,
    input riscv_pkg::ex_mem_t       ex_mem,
    input riscv_pkg::mem_wb_t       mem_wb,
    input riscv_pkg::fwd_sel_e      rs1_fwd,
    input riscv_pkg::fwd_sel_e      rs2_fwd
);
    import riscv_pkg::*;

    int fail_count = 0;

    // PC holds while the load-use bubble goes in
    a_stall_hold: assert property (@(posedge clk) disable iff (rst)
        stall |=> instr_addr == $past(instr_addr))
        else begin
            $error("PC moved during stall");
            fail_count++;
        end

    // Redirect target must be fetched next
    a_flush_pc: assert property (@(posedge clk) disable iff (rst)
        flush |=> instr_addr == $past(redirect_pc))
        else begin
            $error("stale PC after flush");
            fail_count++;
        end

    a_bubble: assert property (@(posedge clk) disable iff (rst)
        (stall || flush) |=> (!id_ex.reg_write && !id_ex.mem_write))
        else begin
            $error("bubble kept write enables");
            fail_count++;
        end

    a_fwd_mem_rd: assert property (@(posedge clk) disable iff (rst)
        (rs1_fwd == FWD_FROM_MEM || rs2_fwd == FWD_FROM_MEM) |-> ex_mem.rd != 5'd0)
        else begin
            $error("forward from MEM with rd zero");
            fail_count++;
        end

    a_fwd_wb_rd: assert property (@(posedge clk) disable iff (rst)
        (rs1_fwd == FWD_FROM_WB || rs2_fwd == FWD_FROM_WB) |-> mem_wb.rd != 5'd0)
        else begin
            $error("forward from WB with rd zero");
            fail_count++;
        end

endmodule

bind riscv_pipeline riscv_pipeline_assertions assertions_inst (
    .clk(clk), .rst(rst), .stall(stall), .flush(flush),
    .redirect_pc(redirect_pc), .instr_addr(instr_addr),
    .id_ex(id_ex), .ex_mem(ex_mem), .mem_wb(mem_wb),
    .rs1_fwd(rs1_fwd), .rs2_fwd(rs2_fwd)
);

`default_nettype wire

//--- tb/riscv_pipeline_tb.sv
`timescale 1ns/10ps
`default_nettype none

`include "riscv_macros.svh"

module riscv_pipeline_tb;
    import riscv_pkg::*;

    typedef enum logic [2:0] {HZ_FWD, HZ_LOAD, HZ_BEQ_TAKEN, HZ_BEQ_NOT, HZ_JAL} hazard_e;

    typedef struct packed {
        alu_op_e     op;
        logic        use_imm;
        logic [11:0] a;
        logic [11:0] b;
        hazard_e     kind;
        logic [31:0] expected;
    } row_t;

    logic             clk;
    logic             rst;
    logic [`XLEN-1:0] instr;
    logic [`XLEN-1:0] mem_read_data;
    logic [`XLEN-1:0] instr_addr;
    logic [`XLEN-1:0] mem_addr;
    logic [`XLEN-1:0] mem_write_data;
    logic             ram_write;
    logic [31:0]      imem [256];
    logic [31:0]      dmem [256];
    row_t             rows [$];
    int               prog_len;
    int               timeouts;
    logic [15:0]      lfsr_state;

    riscv_pipeline riscv_pipeline_inst (
        .clk(clk), .rst(rst), .instr(instr), .mem_read_data(mem_read_data),
        .instr_addr(instr_addr), .mem_addr(mem_addr),
        .mem_write_data(mem_write_data), .ram_write(ram_write)
    );

    riscv_pipeline_checker checker_inst (
        .clk(clk), .rst(rst), .instr_addr(instr_addr), .mem_addr(mem_addr),
        .mem_write_data(mem_write_data), .ram_write(ram_write)
    );

    always #2 clk = ~clk;

    // Both memories answer in the cycle of their address
    assign instr         = imem[instr_addr[9:2]];
    assign mem_read_data = dmem[mem_addr[9:2]];

    always @(posedge clk) begin
        if (ram_write) begin
            dmem[mem_addr[9:2]] <= mem_write_data;
        end
    end

    function automatic logic [31:0] sext(input logic [11:0] v);
        return {{20{v[11]}}, v};
    endfunction

    // Architectural RV32I result of one table row
    function automatic logic [31:0] rv32i_result(input alu_op_e op, input logic [11:0] a,
                                                 input logic [11:0] b);
        logic [31:0] x;
        logic [31:0] y;
        x = sext(a);
        y = sext(b);
        case (op)
            ALU_SUB:    return x - y;
            ALU_AND:    return x & y;
            ALU_OR:     return x | y;
            ALU_XOR:    return x ^ y;
            ALU_SLT:    return ($signed(x) < $signed(y)) ? 32'd1 : 32'd0;
            ALU_PASS_B: return {8'd0, a, 12'd0};
            default:    return x + y;
        endcase
    endfunction

    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    task automatic draw_imm(output logic [11:0] v);
        v = '0;
        for (int i = 0; i < 12; i++) begin
            v = {lfsr_state[0], v[11:1]};
            lfsr_state = lfsr_step(lfsr_state);
        end
    endtask

    task automatic add_row(input alu_op_e op, input logic use_imm, input logic [11:0] a,
                           input logic [11:0] b, input hazard_e kind);
        row_t r;
        r.op       = op;
        r.use_imm  = use_imm;
        r.a        = a;
        r.b        = b;
        r.kind     = kind;
        r.expected = rv32i_result(op, a, b);
        rows.push_back(r);
    endtask

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] enc_beq(input logic [12:0] imm, input logic [4:0] rs2,
                                            input logic [4:0] rs1);
        return {imm[12], imm[10:5], rs2, rs1, 3'b000, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] enc_jal(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    endfunction

    function automatic logic [31:0] enc_op(input row_t r, input logic [4:0] rs1);
        if (r.op == ALU_PASS_B) begin
            return {8'd0, r.a, 5'd3, 7'b0110111};
        end else if (r.use_imm) begin
            return enc_i(r.b, rs1, 3'b000, 5'd3, 7'b0010011);
        end
        case (r.op)
            ALU_SUB: return {7'h20, 5'd2, rs1, 3'b000, 5'd3, 7'b0110011};
            ALU_SLT: return {7'h00, 5'd2, rs1, 3'b010, 5'd3, 7'b0110011};
            ALU_XOR: return {7'h00, 5'd2, rs1, 3'b100, 5'd3, 7'b0110011};
            ALU_OR:  return {7'h00, 5'd2, rs1, 3'b110, 5'd3, 7'b0110011};
            ALU_AND: return {7'h00, 5'd2, rs1, 3'b111, 5'd3, 7'b0110011};
            default: return {7'h00, 5'd2, rs1, 3'b000, 5'd3, 7'b0110011};
        endcase
    endfunction

    task automatic emit(input logic [31:0] word);
        imem[prog_len] = word;
        prog_len++;
    endtask

    // Two ADDIs, an optional hazard pattern, the operation and its store
    task automatic assemble_row(input int idx, input row_t r);
        logic [11:0] addr;
        logic [4:0]  src;
        logic [31:0] jal_pc;
        addr = 12'h200 + 12'(idx * 16);
        src  = 5'd1;
        emit(enc_i(r.a, 5'd0, 3'b000, 5'd1, 7'b0010011));
        emit(enc_i(r.b, 5'd0, 3'b000, 5'd2, 7'b0010011));
        case (r.kind)
            HZ_LOAD: begin
                emit(enc_s(addr + 12'd12, 5'd1, 5'd0));
                emit(enc_i(addr + 12'd12, 5'd0, 3'b010, 5'd4, 7'b0000011));
                checker_inst.expect_store({20'd0, addr + 12'd12}, sext(r.a));
                src = 5'd4;
            end
            HZ_BEQ_TAKEN: begin
                emit(enc_beq(13'd12, 5'd2, 5'd1));
                emit(enc_s(addr + 12'd4, 5'd1, 5'd0));
                emit(enc_s(addr + 12'd8, 5'd2, 5'd0));
            end
            HZ_BEQ_NOT: begin
                emit(enc_beq(13'd12, 5'd2, 5'd1));
                emit(enc_s(addr + 12'd4, 5'd1, 5'd0));
                checker_inst.expect_store({20'd0, addr + 12'd4}, sext(r.a));
            end
            HZ_JAL: begin
                jal_pc = 32'(prog_len * 4);
                emit(enc_jal(21'd12, 5'd5));
                emit(enc_s(addr + 12'd4, 5'd1, 5'd0));
                emit(enc_s(addr + 12'd8, 5'd2, 5'd0));
                emit(enc_s(addr + 12'd4, 5'd5, 5'd0));
                checker_inst.expect_store({20'd0, addr + 12'd4}, jal_pc + 32'd4);
            end
            default: ;
        endcase
        emit(enc_op(r, src));
        emit(enc_s(addr, 5'd3, 5'd0));
        checker_inst.expect_store({20'd0, addr}, r.expected);
    endtask

    initial begin
        logic [11:0] ra;
        logic [11:0] rb;
        int          cycles;
        int          limit;
        clk        = 1'b0;
        rst        = 1'b1;
        prog_len   = 0;
        timeouts   = 0;
        lfsr_state = 16'd50;
        for (int i = 0; i < 256; i++) begin
            imem[i] = `INST_NOP;
            dmem[i] = 32'(i * 4) ^ 32'h5A5A_0000;
        end

        add_row(ALU_ADD, 1'b0, 12'd100, 12'd23, HZ_FWD);
        add_row(ALU_SUB, 1'b0, 12'd5, 12'd300, HZ_FWD);
        add_row(ALU_AND, 1'b0, 12'h0F0, 12'h3CC, HZ_FWD);
        add_row(ALU_OR, 1'b0, 12'h0F0, 12'h30C, HZ_FWD);
        add_row(ALU_XOR, 1'b0, 12'h7A5, 12'h0FF, HZ_FWD);
        add_row(ALU_SLT, 1'b0, 12'hFFB, 12'd3, HZ_FWD);
        add_row(ALU_SLT, 1'b0, 12'd7, 12'hFFE, HZ_FWD);
        add_row(ALU_ADD, 1'b1, 12'hFEC, 12'd55, HZ_FWD);
        add_row(ALU_PASS_B, 1'b0, 12'h5A3, 12'd0, HZ_FWD);
        add_row(ALU_ADD, 1'b0, 12'h123, 12'h456, HZ_LOAD);
        add_row(ALU_SUB, 1'b0, 12'h800, 12'h001, HZ_LOAD);
        add_row(ALU_ADD, 1'b0, 12'd9, 12'd9, HZ_BEQ_TAKEN);
        add_row(ALU_XOR, 1'b0, 12'd4, 12'd6, HZ_BEQ_NOT);
        add_row(ALU_OR, 1'b0, 12'h011, 12'h220, HZ_JAL);
        for (int i = 0; i < 6; i++) begin
            draw_imm(ra);
            draw_imm(rb);
            add_row(alu_op_e'(3'(i % 6)), 1'b0, ra, rb, HZ_FWD);
        end

        foreach (rows[i]) begin
            assemble_row(i, rows[i]);
        end
        // Park the core in a jump to itself
        emit(enc_jal(21'd0, 5'd0));
        limit = 4 * prog_len + 50;

        repeat (10) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        cycles = 0;
        while (checker_inst.pending() > 0 && cycles < limit) begin
            @(negedge clk);
            cycles++;
        end
        if (checker_inst.pending() > 0) begin
            $display("Timeout after %0d cycles with stores still outstanding", cycles);
            timeouts = 1;
        end
        // Skipped stores must stay off the port
        repeat (10) @(negedge clk);
        checker_inst.report_missing();

        $display("Summary: %0d value errors, %0d missing, %0d assertion fails, %0d timeouts",
                 checker_inst.error_count, checker_inst.missing_count,
                 riscv_pipeline_inst.assertions_inst.fail_count, timeouts);
        if (checker_inst.error_count == 0 && checker_inst.missing_count == 0 &&
            riscv_pipeline_inst.assertions_inst.fail_count == 0 && timeouts == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- riscv_pipeline.f
+incdir+include
verilog/riscv_pkg.sv
verilog/riscv_regfile.sv
verilog/riscv_hazard_unit.sv
verilog/riscv_front_end.sv
verilog/riscv_execute.sv
verilog/riscv_mem_wb.sv
verilog/riscv_pipeline.sv
tb/riscv_pipeline_checker.sv
tb/riscv_pipeline_assertions.sv
tb/riscv_pipeline_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= riscv_pipeline_tb
FILELIST  ?= riscv_pipeline.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?=

sim:
	$(VERILATOR) --binary --timing --assert $(VFLAGS) --top-module $(TOP) \
		-f $(FILELIST) -Mdir $(BUILD_DIR) -o sim_bin
	./$(BUILD_DIR)/sim_bin 2>&1 | tee $(LOG)
	@if grep -q "ERRORS FOUND" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	fi
	@if ! grep -q "NO ERRORS" $(LOG); then \
		echo "Simulation ended early, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

.PHONY: sim clean
